// ==== dv/dmem_checker.sv ====
`timescale 1ns/1ps

// Response checker for the data memory port
// Pairs every accepted request with the response one cycle later,
// watches the timer interrupt and keeps the pass and fail counts

module dmem_checker (
    input logic                               clk,
    input logic                               i_req_ack,
    input mem_if_pkg::mem_resp_e              i_resp,
    input logic [mem_if_pkg::DMEM_DWIDTH-1:0] i_rdata,
    input logic                               i_timer_irq
);

    import mem_if_pkg::*;

    localparam int CHK_NONE  = 0;
    localparam int CHK_DATA  = 1;
    localparam int CHK_DELTA = 2;  // Against the previous timer read

    int          cyc = 0;          // Rising edges seen so far
    int          n_pass = 0;
    int          n_fail = 0;
    int          exp_idx[$];
    int          exp_due[$];
    int          exp_mode[$];
    mem_resp_e   exp_resp[$];
    logic [31:0] exp_rdata[$];
    logic        have_ref = 1'b0;
    logic [31:0] ref_val = '0;
    int          ref_cyc = 0;

    always @(posedge clk) cyc <= cyc + 1;

    // Called by the driver just before the accepting edge
    task automatic expect_resp(input int idx, input mem_resp_e resp,
                               input logic [31:0] rdata, input int mode);
        exp_idx.push_back(idx);
        exp_due.push_back(cyc + 1);
        exp_resp.push_back(resp);
        exp_rdata.push_back(rdata);
        exp_mode.push_back(mode);
    endtask

    //------------------------------
    // Response compare
    //------------------------------
    task automatic check_front();
        int          idx;
        int          due;
        int          mode;
        mem_resp_e   resp;
        logic [31:0] rdata;
        logic        ok;
        idx   = exp_idx.pop_front();
        due   = exp_due.pop_front();
        mode  = exp_mode.pop_front();
        resp  = exp_resp.pop_front();
        rdata = exp_rdata.pop_front();
        ok    = 1'b1;
        if (mode == CHK_DELTA) begin
            if (have_ref) rdata = ref_val + (due - ref_cyc);
            else mode = CHK_NONE;    // First read only sets the reference
            have_ref = 1'b1;
            ref_val  = i_rdata;
            ref_cyc  = due;
        end
        if (i_resp === MEM_RESP_IDLE) begin
            $display("Entry %0d: no response in the cycle after acceptance at %0t", idx, $time);
            ok = 1'b0;
        end else if (i_resp !== resp) begin
            $display("MISMATCH at %0t: o_resp expected %s actual %s (entry %0d)",
                     $time, resp.name(), i_resp.name(), idx);
            ok = 1'b0;
        end
        if (mode != CHK_NONE && i_rdata !== rdata) begin
            $display("MISMATCH at %0t: o_rdata expected %h actual %h (entry %0d)",
                     $time, rdata, i_rdata, idx);
            ok = 1'b0;
        end
        if (ok) begin
            $display("Entry %0d ok: %s rdata %h", idx, i_resp.name(), i_rdata);
            n_pass++;
        end else begin
            n_fail++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (exp_due.size() > 0 && exp_due[0] == cyc) begin
            check_front();
        end else if (i_resp !== MEM_RESP_IDLE) begin
            $display("Unexpected response %s at %0t with no request accepted",
                     i_resp.name(), $time);
            n_fail++;
        end
    end

    // No request may be accepted while reset is applied
    task automatic check_reset_ack();
        @(negedge clk);
        if (i_req_ack === 1'b0) begin
            $display("Request ack low during reset: ok");
            n_pass++;
        end else begin
            $display("MISMATCH at %0t: o_req_ack expected 0 actual %b", $time, i_req_ack);
            n_fail++;
        end
    endtask

    //------------------------------
    // Interrupt watch
    //------------------------------
    task automatic wait_irq(input logic level, input int max_cyc, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (i_timer_irq !== level && n < max_cyc) begin
            @(negedge clk);
            n++;
        end
        if (i_timer_irq === level) begin
            $display("%s: ok after %0d cycles", what, n);
            n_pass++;
        end else begin
            $display("%s: o_timer_irq did not reach %b within %0d cycles", what, level, max_cyc);
            n_fail++;
        end
    endtask

    task automatic close_report();
        if (exp_due.size() != 0) begin
            $display("%0d accepted requests never got a response", exp_due.size());
            n_fail += exp_due.size();
        end
        $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
    endtask

endmodule : dmem_checker

// ==== dv/tb_dmem_subsys.sv ====
`timescale 1ns/1ps

// Testbench for the data memory subsystem
// Table-driven requests to the TCM, the timer and unmapped space,
// followed by a walk through the timer interrupt

module tb_dmem_subsys;

    import mem_if_pkg::*;
    import mem_map_pkg::*;

    localparam int          CLK_PERIOD = 40;
    localparam int          SEED       = 18714;
    localparam logic [1:0]  CHK_NONE   = 2'd0;
    localparam logic [1:0]  CHK_DATA   = 2'd1;
    localparam logic [1:0]  CHK_DELTA  = 2'd2;
    localparam logic [31:0] TMR        = TIMER_ADDR_PATTERN;
    localparam logic [31:0] IRQ_CMP    = 32'd12;  // Small compare for the irq walk

    typedef struct packed {
        mem_cmd_e    cmd;
        mem_width_e  width;
        logic [31:0] addr;
        logic [31:0] wdata;
        mem_resp_e   resp;
        logic [31:0] rdata;
        logic [1:0]  mode;
    } entry_t;

    logic        clk;
    logic        rst_n_out;
    logic        req;
    mem_cmd_e    cmd;
    mem_width_e  width;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        req_ack;
    logic [31:0] rdata;
    mem_resp_e   resp;
    logic        timer_irq;
    entry_t      tbl[$];
    int          n_table;          // Entries before the irq walk
    logic        tbl_ready = 1'b0;

    dmem_subsys_top i_dut (
        .clk         (clk),
        .rst_n_out   (rst_n_out),
        .i_req       (req),
        .i_cmd       (cmd),
        .i_width     (width),
        .i_addr      (addr),
        .i_wdata     (wdata),
        .o_req_ack   (req_ack),
        .o_rdata     (rdata),
        .o_resp      (resp),
        .o_timer_irq (timer_irq)
    );

    dmem_checker i_chk (
        .clk         (clk),
        .i_req_ack   (req_ack),
        .i_resp      (resp),
        .i_rdata     (rdata),
        .i_timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //------------------------------
    // Table helpers
    //------------------------------
    task automatic add_entry(input mem_cmd_e c, input mem_width_e w, input logic [31:0] a,
                             input logic [31:0] d, input mem_resp_e r,
                             input logic [31:0] q, input logic [1:0] m);
        entry_t e;
        e = '{c, w, a, d, r, q, m};
        tbl.push_back(e);
    endtask

    task automatic write_entry(input mem_width_e w, input logic [31:0] a,
                               input logic [31:0] d, input mem_resp_e r);
        add_entry(MEM_CMD_WR, w, a, d, r, '0, CHK_NONE);
    endtask

    task automatic read_entry(input mem_width_e w, input logic [31:0] a, input mem_resp_e r,
                              input logic [31:0] q, input logic [1:0] m);
        add_entry(MEM_CMD_RD, w, a, '0, r, q, m);
    endtask

    task automatic build_table();
        logic [31:0] waddr[4];
        logic [31:0] wval[4];
        logic [31:0] base;
        // Random words, one in each of four TCM slices
        for (int i = 0; i < 4; i++) begin
            waddr[i] = TCM_ADDR_PATTERN | ((i * 200 + $urandom % 200) << 2);
            wval[i]  = $urandom;
            write_entry(MEM_WIDTH_WORD, waddr[i], wval[i], MEM_RESP_RDY_OK);
        end
        for (int i = 0; i < 4; i++) begin
            read_entry(MEM_WIDTH_WORD, waddr[i], MEM_RESP_RDY_OK, wval[i], CHK_DATA);
        end
        // Lane merges in the top two words
        base = TCM_ADDR_PATTERN | 32'hFF8;
        write_entry(MEM_WIDTH_WORD, base, 32'h1122_3344, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_BYTE, base + 1, 32'h0000_AB00, MEM_RESP_RDY_OK);   // Lane 1
        write_entry(MEM_WIDTH_HWORD, base + 2, 32'hCDEF_0000, MEM_RESP_RDY_OK);  // Lanes 2-3
        write_entry(MEM_WIDTH_WORD, base + 4, 32'hA5A5_A5A5, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_HWORD, base + 4, 32'h0000_1234, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_BYTE, base + 7, 32'h7700_0000, MEM_RESP_RDY_OK);
        read_entry(MEM_WIDTH_WORD, base, MEM_RESP_RDY_OK, 32'hCDEF_AB44, CHK_DATA);
        read_entry(MEM_WIDTH_WORD, base + 4, MEM_RESP_RDY_OK, 32'h77A5_1234, CHK_DATA);
        // Unmapped space
        read_entry(MEM_WIDTH_WORD, 32'h0050_0000, MEM_RESP_RDY_ER, '0, CHK_DATA);
        write_entry(MEM_WIDTH_WORD, 32'h0049_0100, 32'hDEAD_BEEF, MEM_RESP_RDY_ER);
        read_entry(MEM_WIDTH_WORD, 32'h0049_0100, MEM_RESP_RDY_ER, '0, CHK_DATA);
        // Timer round trip, compare far away
        write_entry(MEM_WIDTH_WORD, TMR | TIMER_CMP_HI_OFS, '0, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_WORD, TMR | TIMER_CMP_LO_OFS, 32'h1000, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_WORD, TMR | TIMER_MTIME_LO_OFS, '0, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_WORD, TMR | TIMER_CTRL_OFS, 32'd1, MEM_RESP_RDY_OK);
        read_entry(MEM_WIDTH_WORD, TMR | TIMER_MTIME_LO_OFS, MEM_RESP_RDY_OK, '0, CHK_DELTA);
        read_entry(MEM_WIDTH_WORD, TMR | TIMER_CTRL_OFS, MEM_RESP_RDY_OK, 32'd1, CHK_DATA);
        read_entry(MEM_WIDTH_WORD, TMR | TIMER_CMP_LO_OFS, MEM_RESP_RDY_OK, 32'h1000, CHK_DATA);
        read_entry(MEM_WIDTH_WORD, TMR | TIMER_MTIME_LO_OFS, MEM_RESP_RDY_OK, '0, CHK_DELTA);
        read_entry(MEM_WIDTH_BYTE, TMR | TIMER_CTRL_OFS, MEM_RESP_RDY_ER, '0, CHK_NONE);
        write_entry(MEM_WIDTH_HWORD, TMR | TIMER_CMP_LO_OFS, 32'd5, MEM_RESP_RDY_ER);
        read_entry(MEM_WIDTH_WORD, TMR | 32'h04, MEM_RESP_RDY_ER, '0, CHK_NONE);  // Hole
        n_table = tbl.size();
        // Interrupt walk
        write_entry(MEM_WIDTH_WORD, TMR | TIMER_MTIME_LO_OFS, '0, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_WORD, TMR | TIMER_CMP_LO_OFS, IRQ_CMP, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_WORD, TMR | TIMER_CMP_LO_OFS, 32'hFFFF_0000, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_WORD, TMR | TIMER_CMP_LO_OFS, IRQ_CMP, MEM_RESP_RDY_OK);
        write_entry(MEM_WIDTH_WORD, TMR | TIMER_CTRL_OFS, '0, MEM_RESP_RDY_OK);
    endtask

    //------------------------------
    // Driver
    //------------------------------
    task automatic drive_entry(input int idx);
        entry_t e;
        e     = tbl[idx];
        req   = 1'b1;
        cmd   = e.cmd;
        width = e.width;
        addr  = e.addr;
        wdata = e.wdata;
        #1;
        while (!req_ack) begin   // Hold until the port accepts
            @(posedge clk);
            #2;
        end
        i_chk.expect_resp(idx, e.resp, e.rdata, e.mode);
        @(posedge clk);
        #2;
        req = 1'b0;
    endtask

    task automatic run_entries(input int first, input int last);
        @(posedge clk);
        #2;
        for (int i = first; i < last; i++) drive_entry(i);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_out = 1'b0;
        req       = 1'b0;
        cmd       = MEM_CMD_RD;
        width     = MEM_WIDTH_WORD;
        addr      = '0;
        wdata     = '0;
        build_table();
        tbl_ready = 1'b1;
        repeat (2) @(posedge clk);
        i_chk.check_reset_ack();
        @(posedge clk);
        #2;
        rst_n_out = 1'b1;
        i_chk.wait_irq(1'b0, 0, "Timer irq low after reset");
        run_entries(0, n_table);
        run_entries(n_table, n_table + 2);
        i_chk.wait_irq(1'b1, IRQ_CMP + 4, "Timer irq rises at mtimecmp");
        run_entries(n_table + 2, n_table + 3);
        i_chk.wait_irq(1'b0, 2, "Timer irq falls after mtimecmp raised");
        run_entries(n_table + 3, n_table + 4);
        i_chk.wait_irq(1'b1, IRQ_CMP + 4, "Timer irq rises again");
        run_entries(n_table + 4, n_table + 5);
        i_chk.wait_irq(1'b0, 2, "Timer irq falls after enable cleared");
        repeat (2) @(posedge clk);
        i_chk.close_report();
        if (i_chk.n_fail == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog, four cycles per entry plus margin
    initial begin
        wait (tbl_ready);
        #((tbl.size() * 4 + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", tbl.size() * 4 + 20);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : tb_dmem_subsys

// ==== sources.f ====
src/mem_if_pkg.sv
src/mem_map_pkg.sv
src/tcm_ram.sv
src/mtimer.sv
src/dmem_router.sv
src/dmem_subsys_top.sv
dv/dmem_checker.sv
dv/tb_dmem_subsys.sv

// ==== src/dmem_router.sv ====
`timescale 1ns/1ps

// Data memory router
// Decodes the master address into the TCM or timer region, forwards the
// request there and merges the one-cycle responses back to the master

module dmem_router (
    input  logic                                  clk,
    input  logic                                  rst_n_out,
    // Master side
    input  logic                                  i_req,
    input  mem_if_pkg::mem_cmd_e                  i_cmd,
    input  mem_if_pkg::mem_width_e                i_width,
    input  logic [mem_if_pkg::DMEM_AWIDTH-1:0]    i_addr,
    input  logic [mem_if_pkg::DMEM_DWIDTH-1:0]    i_wdata,
    output logic                                  o_req_ack,
    output logic [mem_if_pkg::DMEM_DWIDTH-1:0]    o_rdata,
    output mem_if_pkg::mem_resp_e                 o_resp,
    // Port 1, TCM
    output logic                                  o_tcm_req,
    output mem_if_pkg::mem_cmd_e                  o_tcm_cmd,
    output mem_if_pkg::mem_width_e                o_tcm_width,
    output logic [mem_if_pkg::DMEM_AWIDTH-1:0]    o_tcm_addr,
    output logic [mem_if_pkg::DMEM_DWIDTH-1:0]    o_tcm_wdata,
    input  logic                                  i_tcm_req_ack,
    input  logic [mem_if_pkg::DMEM_DWIDTH-1:0]    i_tcm_rdata,
    input  mem_if_pkg::mem_resp_e                 i_tcm_resp,
    // Port 2, timer
    output logic                                  o_tmr_req,
    output mem_if_pkg::mem_cmd_e                  o_tmr_cmd,
    output mem_if_pkg::mem_width_e                o_tmr_width,
    output logic [mem_if_pkg::DMEM_AWIDTH-1:0]    o_tmr_addr,
    output logic [mem_if_pkg::DMEM_DWIDTH-1:0]    o_tmr_wdata,
    input  logic                                  i_tmr_req_ack,
    input  logic [mem_if_pkg::DMEM_DWIDTH-1:0]    i_tmr_rdata,
    input  mem_if_pkg::mem_resp_e                 i_tmr_resp
);

    import mem_if_pkg::*;
    import mem_map_pkg::*;

    typedef enum logic [1:0] {
        PORT_NONE,
        PORT_TCM,
        PORT_TMR,
        PORT_ERR      // No region matched
    } port_sel_e;

    logic      tcm_hit;
    logic      tmr_hit;
    logic      err_ack_q;  // Self-ack for unmapped addresses
    port_sel_e port_d;
    port_sel_e port_q;     // Port owning next cycle's response

    //------------------------------
    // Address decode and steering
    //------------------------------
    assign tcm_hit = (i_addr & TCM_ADDR_MASK) == TCM_ADDR_PATTERN;
    assign tmr_hit = (i_addr & TIMER_ADDR_MASK) == TIMER_ADDR_PATTERN;

    assign o_tcm_req   = i_req & tcm_hit;
    assign o_tcm_cmd   = i_cmd;
    assign o_tcm_width = i_width;
    assign o_tcm_addr  = i_addr;
    assign o_tcm_wdata = i_wdata;

    assign o_tmr_req   = i_req & tmr_hit;
    assign o_tmr_cmd   = i_cmd;
    assign o_tmr_width = i_width;
    assign o_tmr_addr  = i_addr;
    assign o_tmr_wdata = i_wdata;

    always_comb begin
        if (tcm_hit) begin
            o_req_ack = i_tcm_req_ack;
            port_d    = PORT_TCM;
        end else if (tmr_hit) begin
            o_req_ack = i_tmr_req_ack;
            port_d    = PORT_TMR;
        end else begin
            o_req_ack = err_ack_q;
            port_d    = PORT_ERR;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_out) begin
            err_ack_q <= 1'b0;
            port_q    <= PORT_NONE;
        end else begin
            err_ack_q <= 1'b1;
            port_q    <= (i_req && o_req_ack) ? port_d : PORT_NONE;
        end
    end

    //------------------------------
    // Response merge
    //------------------------------
    always_comb begin
        case (port_q)
            PORT_TCM: begin
                o_resp  = i_tcm_resp;
                o_rdata = i_tcm_rdata;
            end
            PORT_TMR: begin
                o_resp  = i_tmr_resp;
                o_rdata = i_tmr_rdata;
            end
            PORT_ERR: begin
                o_resp  = MEM_RESP_RDY_ER;
                o_rdata = '0;
            end
            default: begin
                o_resp  = MEM_RESP_IDLE;
                o_rdata = '0;
            end
        endcase
    end

    // Checks
    a_one_port_req: assert property (@(posedge clk) disable iff (!rst_n_out)
        !(o_tcm_req && o_tmr_req));

    a_resp_after_accept: assert property (@(posedge clk) disable iff (!rst_n_out)
        (o_resp != MEM_RESP_IDLE) == $past(i_req && o_req_ack));

    // Master must hold its request while stalled
    a_req_stable: assert property (@(posedge clk)
        (i_req && !o_req_ack) |=> $stable({i_cmd, i_width, i_addr, i_wdata}));

endmodule : dmem_router

// ==== src/dmem_subsys_top.sv ====
`timescale 1ns/1ps

// Data memory subsystem top
// Router in front of the TCM and the machine timer

module dmem_subsys_top (
    input  logic                                  clk,
    input  logic                                  rst_n_out,
    input  logic                                  i_req,
    input  mem_if_pkg::mem_cmd_e                  i_cmd,
    input  mem_if_pkg::mem_width_e                i_width,
    input  logic [mem_if_pkg::DMEM_AWIDTH-1:0]    i_addr,
    input  logic [mem_if_pkg::DMEM_DWIDTH-1:0]    i_wdata,
    output logic                                  o_req_ack,
    output logic [mem_if_pkg::DMEM_DWIDTH-1:0]    o_rdata,
    output mem_if_pkg::mem_resp_e                 o_resp,
    output logic                                  o_timer_irq
);

    import mem_if_pkg::*;

    // Router to TCM
    logic                   tcm_req;
    mem_cmd_e               tcm_cmd;
    mem_width_e             tcm_width;
    logic [DMEM_AWIDTH-1:0] tcm_addr;
    logic [DMEM_DWIDTH-1:0] tcm_wdata;
    logic                   tcm_req_ack;
    logic [DMEM_DWIDTH-1:0] tcm_rdata;
    mem_resp_e              tcm_resp;

    // Router to timer
    logic                   tmr_req;
    mem_cmd_e               tmr_cmd;
    mem_width_e             tmr_width;
    logic [DMEM_AWIDTH-1:0] tmr_addr;
    logic [DMEM_DWIDTH-1:0] tmr_wdata;
    logic                   tmr_req_ack;
    logic [DMEM_DWIDTH-1:0] tmr_rdata;
    mem_resp_e              tmr_resp;

    dmem_router i_dmem_router (
        .clk           (clk),
        .rst_n_out     (rst_n_out),
        .i_req         (i_req),
        .i_cmd         (i_cmd),
        .i_width       (i_width),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .o_req_ack     (o_req_ack),
        .o_rdata       (o_rdata),
        .o_resp        (o_resp),
        .o_tcm_req     (tcm_req),
        .o_tcm_cmd     (tcm_cmd),
        .o_tcm_width   (tcm_width),
        .o_tcm_addr    (tcm_addr),
        .o_tcm_wdata   (tcm_wdata),
        .i_tcm_req_ack (tcm_req_ack),
        .i_tcm_rdata   (tcm_rdata),
        .i_tcm_resp    (tcm_resp),
        .o_tmr_req     (tmr_req),
        .o_tmr_cmd     (tmr_cmd),
        .o_tmr_width   (tmr_width),
        .o_tmr_addr    (tmr_addr),
        .o_tmr_wdata   (tmr_wdata),
        .i_tmr_req_ack (tmr_req_ack),
        .i_tmr_rdata   (tmr_rdata),
        .i_tmr_resp    (tmr_resp)
    );

    tcm_ram i_tcm_ram (
        .clk       (clk),
        .rst_n_out (rst_n_out),
        .i_req     (tcm_req),
        .i_cmd     (tcm_cmd),
        .i_width   (tcm_width),
        .i_addr    (tcm_addr),
        .i_wdata   (tcm_wdata),
        .o_req_ack (tcm_req_ack),
        .o_rdata   (tcm_rdata),
        .o_resp    (tcm_resp)
    );

    mtimer i_mtimer (
        .clk         (clk),
        .rst_n_out   (rst_n_out),
        .i_req       (tmr_req),
        .i_cmd       (tmr_cmd),
        .i_width     (tmr_width),
        .i_addr      (tmr_addr),
        .i_wdata     (tmr_wdata),
        .o_req_ack   (tmr_req_ack),
        .o_rdata     (tmr_rdata),
        .o_resp      (tmr_resp),
        .o_timer_irq (o_timer_irq)  // Straight to the top
    );

endmodule : dmem_subsys_top

// ==== src/mem_if_pkg.sv ====
// Memory port definitions
// Command, access width and response codes shared by every block on the
// data memory request port, plus the address and data widths

package mem_if_pkg;

    //------------------------------
    // Port widths
    //------------------------------
    localparam int DMEM_AWIDTH = 32;
    localparam int DMEM_DWIDTH = 32;

    //------------------------------
    // Request encodings
    //------------------------------
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // Response code, idle in every cycle without a completion
    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

endpackage : mem_if_pkg

// ==== src/mem_map_pkg.sv ====
// Data memory address map
// Regions of the TCM and the machine timer, TCM depth and timer
// register offsets

package mem_map_pkg;

    //------------------------------
    // TCM region
    //------------------------------
    localparam logic [31:0] TCM_ADDR_PATTERN = 32'h0048_0000;
    localparam logic [31:0] TCM_ADDR_MASK    = 32'hFFFF_F000;  // 4 KB window
    localparam int          TCM_DEPTH        = 1024;           // 32-bit words

    //------------------------------
    // Timer region
    //------------------------------
    localparam logic [31:0] TIMER_ADDR_PATTERN = 32'h0049_0000;
    localparam logic [31:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0;

    // Register offsets inside the timer window
    localparam logic [4:0] TIMER_CTRL_OFS     = 5'h00;  // Bit 0 is enable
    localparam logic [4:0] TIMER_MTIME_LO_OFS = 5'h08;
    localparam logic [4:0] TIMER_MTIME_HI_OFS = 5'h0C;
    localparam logic [4:0] TIMER_CMP_LO_OFS   = 5'h10;
    localparam logic [4:0] TIMER_CMP_HI_OFS   = 5'h14;

endpackage : mem_map_pkg

// ==== src/mtimer.sv ====
`timescale 1ns/1ps

// Machine timer
// 64-bit mtime and mtimecmp as 32-bit halves, enable bit, and a
// registered timer interrupt; word accesses only

module mtimer (
    input  logic                                  clk,
    input  logic                                  rst_n_out,
    input  logic                                  i_req,
    input  mem_if_pkg::mem_cmd_e                  i_cmd,
    input  mem_if_pkg::mem_width_e                i_width,
    input  logic [mem_if_pkg::DMEM_AWIDTH-1:0]    i_addr,
    input  logic [mem_if_pkg::DMEM_DWIDTH-1:0]    i_wdata,
    output logic                                  o_req_ack,
    output logic [mem_if_pkg::DMEM_DWIDTH-1:0]    o_rdata,
    output mem_if_pkg::mem_resp_e                 o_resp,
    output logic                                  o_timer_irq
);

    import mem_if_pkg::*;
    import mem_map_pkg::*;

    logic [4:0]  ofs;
    logic        ofs_ok;
    logic        acc;
    logic        err;
    logic        wr_ok;
    logic        ack_q;
    logic        en_d;
    logic        en_q;
    logic [63:0] mtime_q;
    logic [63:0] cmp_q;
    logic [31:0] rd_mux;

    assign ofs       = i_addr[4:0];
    assign acc       = i_req & ack_q;
    assign o_req_ack = ack_q;

    //------------------------------
    // Register decode
    //------------------------------
    always_comb begin
        ofs_ok = 1'b1;
        rd_mux = '0;
        case (ofs)
            TIMER_CTRL_OFS:     rd_mux = {31'd0, en_q};
            TIMER_MTIME_LO_OFS: rd_mux = mtime_q[31:0];
            TIMER_MTIME_HI_OFS: rd_mux = mtime_q[63:32];
            TIMER_CMP_LO_OFS:   rd_mux = cmp_q[31:0];
            TIMER_CMP_HI_OFS:   rd_mux = cmp_q[63:32];
            default:            ofs_ok = 1'b0;
        endcase
    end

    assign err   = (i_width != MEM_WIDTH_WORD) | ~ofs_ok;  // Sub-word or hole
    assign wr_ok = acc & (i_cmd == MEM_CMD_WR) & ~err;

    // Next enable, so the interrupt drops together with it
    always_comb begin
        en_d = en_q;
        if (wr_ok && (ofs == TIMER_CTRL_OFS)) en_d = i_wdata[0];
    end

    always_ff @(posedge clk) begin
        if (acc && (i_cmd == MEM_CMD_RD)) o_rdata <= err ? '0 : rd_mux;
    end

    //------------------------------
    // Counter, compare, interrupt
    //------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_out) begin
            ack_q       <= 1'b0;
            o_resp      <= MEM_RESP_IDLE;
            en_q        <= 1'b0;
            mtime_q     <= '0;
            cmp_q       <= '0;
            o_timer_irq <= 1'b0;
        end else begin
            ack_q  <= 1'b1;
            o_resp <= !acc ? MEM_RESP_IDLE : (err ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK);
            en_q   <= en_d;
            // A write to either half replaces this cycle's increment
            if (wr_ok && (ofs == TIMER_MTIME_LO_OFS)) mtime_q[31:0] <= i_wdata;
            else if (wr_ok && (ofs == TIMER_MTIME_HI_OFS)) mtime_q[63:32] <= i_wdata;
            else if (en_q) mtime_q <= mtime_q + 64'd1;
            if (wr_ok && (ofs == TIMER_CMP_LO_OFS)) cmp_q[31:0] <= i_wdata;
            if (wr_ok && (ofs == TIMER_CMP_HI_OFS)) cmp_q[63:32] <= i_wdata;
            o_timer_irq <= en_d & (mtime_q >= cmp_q);
        end
    end

    a_irq_needs_en: assert property (@(posedge clk) disable iff (!rst_n_out)
        !en_q |-> !o_timer_irq);

endmodule : mtimer

// ==== src/tcm_ram.sv ====
`timescale 1ns/1ps

// Tightly coupled data RAM
// Single port, byte-lane writes, whole-word reads one cycle after accept

module tcm_ram (
    input  logic                                  clk,
    input  logic                                  rst_n_out,
    input  logic                                  i_req,
    input  mem_if_pkg::mem_cmd_e                  i_cmd,
    input  mem_if_pkg::mem_width_e                i_width,
    input  logic [mem_if_pkg::DMEM_AWIDTH-1:0]    i_addr,
    input  logic [mem_if_pkg::DMEM_DWIDTH-1:0]    i_wdata,
    output logic                                  o_req_ack,
    output logic [mem_if_pkg::DMEM_DWIDTH-1:0]    o_rdata,
    output mem_if_pkg::mem_resp_e                 o_resp
);

    import mem_if_pkg::*;
    import mem_map_pkg::*;

    logic [DMEM_DWIDTH-1:0]       mem [TCM_DEPTH];
    logic [$clog2(TCM_DEPTH)-1:0] word_idx;
    logic [3:0]                   byte_en;
    logic                         acc;
    logic                         ack_q;

    assign acc       = i_req & ack_q;
    assign o_req_ack = ack_q;
    assign word_idx  = i_addr[$clog2(TCM_DEPTH)+1:2];  // Word index below the mask

    // Lane select from width and low address bits
    always_comb begin
        case (i_width)
            MEM_WIDTH_BYTE:  byte_en = 4'b0001 << i_addr[1:0];
            MEM_WIDTH_HWORD: byte_en = i_addr[1] ? 4'b1100 : 4'b0011;
            default:         byte_en = 4'b1111;
        endcase
    end

    //------------------------------
    // Array access
    //------------------------------
    always_ff @(posedge clk) begin
        if (acc && (i_cmd == MEM_CMD_WR)) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) mem[word_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
            end
        end
        if (acc && (i_cmd == MEM_CMD_RD)) begin
            o_rdata <= mem[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_out) begin
            ack_q  <= 1'b0;
            o_resp <= MEM_RESP_IDLE;
        end else begin
            ack_q  <= 1'b1;                                // Never stalls
            o_resp <= acc ? MEM_RESP_RDY_OK : MEM_RESP_IDLE;
        end
    end

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n_out)
        acc |-> ((i_width != MEM_WIDTH_HWORD) || !i_addr[0]) &&
                ((i_width != MEM_WIDTH_WORD) || (i_addr[1:0] == 2'b00)));

endmodule : tcm_ram
